// ==== mb4_pkg.sv ====
// Shared address map, widths, register bit positions and bus structs for the motor board core
package mb4_pkg;

	////////////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////////////
	localparam int NUM_MOTORS  = 4;
	localparam int MOTOR_IDX_W = $clog2(NUM_MOTORS);
	localparam int ADDR_W      = 15;
	localparam int DATA_W      = 32;
	localparam int FRAME_BITS  = 1 + ADDR_W + DATA_W;	// Write flag, address, data
	localparam int BIT_CNT_W   = $clog2(FRAME_BITS + 1);
	localparam int DIPSW_W     = 4;
	localparam int BTN_LED_W   = 6;
	localparam int PWM_FIELD_W = 16;

	localparam logic [DATA_W-1:0] FPGA_VERSION = 32'h0004_0102;

	////////////////////////////////////////////////////////////////////
	// Address map
	////////////////////////////////////////////////////////////////////
	localparam logic [ADDR_W-1:0] ADDR_VER        = 15'h0000;
	localparam logic [ADDR_W-1:0] ADDR_DIP        = 15'h0002;
	localparam logic [ADDR_W-1:0] ADDR_BUTTONS    = 15'h0004;
	localparam logic [ADDR_W-1:0] ADDR_BUTTON_LED = 15'h0005;

	localparam logic [ADDR_W-1:0] ADDR_MOTOR_BASE = 15'h0100;
	localparam logic [ADDR_W-1:0] MOTOR_STRIDE    = 15'h0010;

	// Offsets inside one motor block
	localparam logic [ADDR_W-1:0] OFS_INC      = 15'd0;
	localparam logic [ADDR_W-1:0] OFS_INC_ERR  = 15'd1;
	localparam logic [ADDR_W-1:0] OFS_PWM      = 15'd2;
	localparam logic [ADDR_W-1:0] OFS_FEEDBACK = 15'd3;
	localparam logic [ADDR_W-1:0] OFS_DRV_CTRL = 15'd4;

	localparam logic [DATA_W-1:0] UNMAPPED_DATA = '1;

	// Register bit positions
	localparam int DRV_EN_BIT     = 0;
	localparam int DRV_BRAKE_BIT  = 1;
	localparam int PWM_PERIOD_LSB = 0;	// Period in clocks
	localparam int PWM_HIGH_LSB   = 16;	// High time in clocks

	////////////////////////////////////////////////////////////////////
	// Structs
	////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic              wr;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} spi_req_t;

	typedef struct packed {
		logic b;
		logic a;
	} quad_pins_t;

	typedef struct packed {
		logic [DIPSW_W-1:0] dipsw;
		logic               btn3nc;
		logic               btn3no;
		logic               btn2nc;
		logic               btn2no;
	} board_pins_t;

	typedef struct packed {
		quad_pins_t quad;
		logic       nfault;	// Active low driver fault
		logic       fgout;
	} motor_pins_t;

	typedef struct packed {
		logic              inc_clr;
		logic              pwm_wr;
		logic              drv_wr;
		logic [DATA_W-1:0] data;
	} motor_cmd_t;

	typedef struct packed {
		logic [DATA_W-1:0] count;
		logic [DATA_W-1:0] errors;
		logic [DATA_W-1:0] pwm_word;
		logic [DATA_W-1:0] drv_ctrl;
		logic              nfault;
		logic              fgout;
	} motor_stat_t;

endpackage

// ==== input_sync.sv ====
// Two-flop synchronizer for a group of asynchronous board pins, payload type set per instance
module input_sync #(
	parameter type payload_t = logic
)
(
	input  logic     clk_100m,
	input  logic     Master_rstn,
	input  payload_t d,
	output payload_t q
);

	payload_t meta;	// First stage, may go metastable

	always_ff @(posedge clk_100m or negedge Master_rstn)
	begin
		if (!Master_rstn)
		begin
			meta <= '0;
			q    <= '0;
		end
		else
		begin
			meta <= d;
			q    <= meta;
		end
	end

endmodule

// ==== spi_slave.sv ====
// SPI mode-0 slave: turns 48-bit host frames into register requests and shifts read data out
module spi_slave import mb4_pkg::*;
(
	input  logic              clk_100m,
	input  logic              Master_rstn,
	input  logic              mclk_0,
	input  logic              mosi_0,
	input  logic              cs_00,
	output logic              miso_0,
	output spi_req_t          req,
	output logic              req_valid,
	input  logic [DATA_W-1:0] rd_data
);

	logic [2:0]            sclk_s;
	logic [1:0]            cs_s;
	logic [1:0]            mosi_s;
	logic                  sclk_rise;
	logic                  sclk_fall;
	logic                  cs_act;
	logic                  tx_phase;
	logic [BIT_CNT_W-1:0]  bit_cnt;
	logic [FRAME_BITS-1:0] rx_sr;
	logic [FRAME_BITS-1:0] rx_next;
	logic [DATA_W-1:0]     tx_sr;

	////////////////////////////////////////////////////////////////////
	// Pin sampling and edge detect in the system clock domain
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_100m or negedge Master_rstn)
	begin
		if (!Master_rstn)
		begin
			sclk_s <= '0;
			cs_s   <= '1;	// Deselected
			mosi_s <= '0;
		end
		else
		begin
			sclk_s <= {sclk_s[1:0], mclk_0};
			cs_s   <= {cs_s[0], cs_00};
			mosi_s <= {mosi_s[0], mosi_0};	// Aligned with sclk_s[1]
		end
	end

	assign sclk_rise = (sclk_s[2:1] == 2'b01);
	assign sclk_fall = (sclk_s[2:1] == 2'b10);
	assign cs_act    = ~cs_s[1];
	assign rx_next   = {rx_sr[FRAME_BITS-2:0], mosi_s[1]};

	// Data phase spans the falling edges after the last address bit
	assign tx_phase = cs_act && (bit_cnt > BIT_CNT_W'(ADDR_W)) &&
		(bit_cnt < BIT_CNT_W'(FRAME_BITS));

	////////////////////////////////////////////////////////////////////
	// Frame counter and request issue
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk_100m or negedge Master_rstn)
	begin
		if (!Master_rstn)
		begin
			bit_cnt   <= '0;
			req       <= '0;
			req_valid <= 1'b0;
			miso_0    <= 1'b0;
		end
		else
		begin
			req_valid <= 1'b0;
			if (!cs_act)
			begin
				bit_cnt <= '0;	// Deselected, partial frames are lost here
				miso_0  <= 1'b0;
			end
			else if (sclk_rise && (bit_cnt < BIT_CNT_W'(FRAME_BITS)))
			begin
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == BIT_CNT_W'(ADDR_W))
				begin
					// Last address bit, ask for the read word
					req.wr    <= 1'b0;
					req.addr  <= rx_next[ADDR_W-1:0];
					req_valid <= 1'b1;
				end
				else if ((bit_cnt == BIT_CNT_W'(FRAME_BITS - 1)) && rx_next[FRAME_BITS-1])
				begin
					req.wr    <= 1'b1;
					req.addr  <= rx_next[DATA_W +: ADDR_W];
					req.data  <= rx_next[DATA_W-1:0];
					req_valid <= 1'b1;
				end
			end
			else if (sclk_fall && tx_phase)
				miso_0 <= tx_sr[DATA_W-1];	// MSB first
		end
	end

	// Shift registers
	always_ff @(posedge clk_100m)
	begin
		if (sclk_rise && cs_act)
			rx_sr <= rx_next;
		if (req_valid && !req.wr)
			tx_sr <= rd_data;	// Read word ready one cycle after the address request
		else if (sclk_fall && tx_phase)
			tx_sr <= {tx_sr[DATA_W-2:0], 1'b0};
	end

endmodule

// ==== quad_decoder.sv ====
// Quadrature decoder keeping a signed position count and a count of illegal double steps
module quad_decoder import mb4_pkg::*;
(
	input  logic              clk_100m,
	input  logic              Master_rstn,
	input  quad_pins_t        pins,
	input  logic              clear,
	output logic [DATA_W-1:0] count,
	output logic [DATA_W-1:0] errors
);

	quad_pins_t prev;
	logic [1:0] step;

	// Gray phase pair to a 2-bit position, forward is 00,01,11,10 on {b,a}
	function automatic logic [1:0] gray_to_bin(input quad_pins_t p);
		return {p.b, p.b ^ p.a};
	endfunction

	assign step = gray_to_bin(pins) - gray_to_bin(prev);	// Modulo 4 distance

	always_ff @(posedge clk_100m or negedge Master_rstn)
	begin
		if (!Master_rstn)
		begin
			prev   <= '0;
			count  <= '0;
			errors <= '0;
		end
		else
		begin
			prev <= pins;
			if (clear)
			begin
				count  <= '0;
				errors <= '0;
			end
			else
			begin
				case (step)
					2'd1:
						count <= count + 1'b1;	// a leads b
					2'd3:
						count <= count - 1'b1;
					2'd2:
						errors <= errors + 1'b1;	// Both phases moved at once
					default:
						;
				endcase
			end
		end
	end

endmodule

// ==== pwm_gen.sv ====
// PWM generator, period and high time in clocks taken from one register word
module pwm_gen import mb4_pkg::*;
(
	input  logic              clk_100m,
	input  logic              Master_rstn,
	input  logic [DATA_W-1:0] cycle_word,
	input  logic              enable,
	output logic              pwm
);

	logic [PWM_FIELD_W-1:0] period;
	logic [PWM_FIELD_W-1:0] high_time;
	logic [PWM_FIELD_W-1:0] cnt;
	logic                   pwm_q;

	assign period    = cycle_word[PWM_PERIOD_LSB +: PWM_FIELD_W];
	assign high_time = cycle_word[PWM_HIGH_LSB +: PWM_FIELD_W];

	always_ff @(posedge clk_100m or negedge Master_rstn)
	begin
		if (!Master_rstn)
		begin
			cnt   <= '0;
			pwm_q <= 1'b0;
		end
		else if (period == '0)
		begin
			cnt   <= '0;	// Stopped
			pwm_q <= 1'b0;
		end
		else
		begin
			if (cnt >= period - 1'b1)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
			pwm_q <= (cnt < high_time);	// min(high, period) clocks per period
		end
	end

	// Enable cuts the output at once, a fault must not wait for the next step
	assign pwm = pwm_q & enable;

endmodule

// ==== motor_channel.sv ====
// One motor channel: PWM and driver registers, fault gating, encoder decoder and PWM output
module motor_channel import mb4_pkg::*;
(
	input  logic        clk_100m,
	input  logic        Master_rstn,
	input  motor_pins_t pins,
	input  motor_cmd_t  cmd,
	output motor_stat_t stat,
	output logic        pwm,
	output logic        brake,
	output logic        droff
);

	motor_pins_t       pins_s;
	logic [DATA_W-1:0] pwm_word;
	logic              drv_en;
	logic              drv_brake;
	logic              pwm_en;
	logic [DATA_W-1:0] count;
	logic [DATA_W-1:0] errors;

	input_sync #(
		.payload_t(motor_pins_t)
	) i_pin_sync (
		.clk_100m(clk_100m),
		.Master_rstn(Master_rstn),
		.d(pins),
		.q(pins_s)
	);

	always_ff @(posedge clk_100m or negedge Master_rstn)
	begin
		if (!Master_rstn)
		begin
			pwm_word  <= '0;
			drv_en    <= 1'b0;
			drv_brake <= 1'b0;
		end
		else
		begin
			if (cmd.pwm_wr)
				pwm_word <= cmd.data;
			if (cmd.drv_wr)
			begin
				drv_en    <= cmd.data[DRV_EN_BIT];
				drv_brake <= cmd.data[DRV_BRAKE_BIT];
			end
		end
	end

	// Low nfault turns the driver off and stops PWM
	assign pwm_en = drv_en & pins_s.nfault;
	assign droff  = ~drv_en | ~pins_s.nfault;
	assign brake  = drv_brake;

	quad_decoder i_quad (
		.clk_100m(clk_100m),
		.Master_rstn(Master_rstn),
		.pins(pins_s.quad),
		.clear(cmd.inc_clr),
		.count(count),
		.errors(errors)
	);

	pwm_gen i_pwm (
		.clk_100m(clk_100m),
		.Master_rstn(Master_rstn),
		.cycle_word(pwm_word),
		.enable(pwm_en),
		.pwm(pwm)
	);

	always_comb
	begin
		stat                         = '0;
		stat.count                   = count;
		stat.errors                  = errors;
		stat.pwm_word                = pwm_word;
		stat.drv_ctrl[DRV_EN_BIT]    = drv_en;
		stat.drv_ctrl[DRV_BRAKE_BIT] = drv_brake;
		stat.nfault                  = pins_s.nfault;
		stat.fgout                   = pins_s.fgout;
	end

endmodule

// ==== reg_bank.sv ====
// Register bank: address decode, board registers, motor write strobes and the read mux
module reg_bank import mb4_pkg::*;
(
	input  logic                 clk_100m,
	input  logic                 Master_rstn,
	input  spi_req_t             req,
	input  logic                 req_valid,
	output logic [DATA_W-1:0]    rd_data,
	input  board_pins_t          board,
	output logic [BTN_LED_W-1:0] btn_led,
	output motor_cmd_t           cmd [NUM_MOTORS],
	input  motor_stat_t          stat [NUM_MOTORS]
);

	logic [ADDR_W-1:0]      rel_addr;
	logic [ADDR_W-1:0]      blk;
	logic [ADDR_W-1:0]      ofs;
	logic [MOTOR_IDX_W-1:0] sel;
	logic                   motor_hit;
	logic                   wr_en;

	////////////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////////////
	assign rel_addr  = req.addr - ADDR_MOTOR_BASE;
	assign blk       = rel_addr / MOTOR_STRIDE;
	assign ofs       = rel_addr % MOTOR_STRIDE;
	assign sel       = blk[MOTOR_IDX_W-1:0];
	assign motor_hit = (req.addr >= ADDR_MOTOR_BASE) && (blk < ADDR_W'(NUM_MOTORS));
	assign wr_en     = req_valid && req.wr;

	// Button LEDs, the only writable board register
	always_ff @(posedge clk_100m or negedge Master_rstn)
	begin
		if (!Master_rstn)
			btn_led <= '0;
		else if (wr_en && (req.addr == ADDR_BUTTON_LED))
			btn_led <= req.data[BTN_LED_W-1:0];
	end

	// One strobe per write, registered inside the channel on the next edge
	always_comb
	begin
		for (int m = 0; m < NUM_MOTORS; m++)
		begin
			cmd[m]      = '0;
			cmd[m].data = req.data;
			if (wr_en && motor_hit && (sel == MOTOR_IDX_W'(m)))
			begin
				cmd[m].inc_clr = (ofs == OFS_INC);
				cmd[m].pwm_wr  = (ofs == OFS_PWM);
				cmd[m].drv_wr  = (ofs == OFS_DRV_CTRL);
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// Read mux
	////////////////////////////////////////////////////////////////////
	always_comb
	begin
		rd_data = UNMAPPED_DATA;
		if (motor_hit)
		begin
			case (ofs)
				OFS_INC:
					rd_data = stat[sel].count;
				OFS_INC_ERR:
					rd_data = stat[sel].errors;
				OFS_PWM:
					rd_data = stat[sel].pwm_word;
				OFS_FEEDBACK:
					rd_data = {{(DATA_W-2){1'b0}}, stat[sel].fgout, stat[sel].nfault};
				OFS_DRV_CTRL:
					rd_data = stat[sel].drv_ctrl;
				default:
					rd_data = UNMAPPED_DATA;	// Hole inside a motor block
			endcase
		end
		else
		begin
			case (req.addr)
				ADDR_VER:
					rd_data = FPGA_VERSION;
				ADDR_DIP:
					rd_data = {{(DATA_W-DIPSW_W){1'b0}}, board.dipsw};
				ADDR_BUTTONS:
					rd_data = {{(DATA_W-4){1'b0}}, board.btn3nc, board.btn3no,
						board.btn2nc, board.btn2no};
				ADDR_BUTTON_LED:
					rd_data = {{(DATA_W-BTN_LED_W){1'b0}}, btn_led};
				default:
					rd_data = UNMAPPED_DATA;
			endcase
		end
	end

endmodule

// ==== top_4mb.sv ====
// Top level of the motor board core, SPI slave, board synchronizer, register bank and motors
module top_4mb import mb4_pkg::*;
(
	input  logic                  clk_100m,
	input  logic                  Master_rstn,
	input  logic                  mclk_0,
	input  logic                  mosi_0,
	input  logic                  cs_00,
	output logic                  miso_0,
	input  logic [NUM_MOTORS-1:0] qca,
	input  logic [NUM_MOTORS-1:0] qcb,
	input  logic [NUM_MOTORS-1:0] nfault,
	input  logic [NUM_MOTORS-1:0] fgout,
	output logic [NUM_MOTORS-1:0] pwm,
	output logic [NUM_MOTORS-1:0] brake,
	output logic [NUM_MOTORS-1:0] droff,
	input  logic [DIPSW_W-1:0]    dipsw,
	input  logic                  btn2no,
	input  logic                  btn2nc,
	input  logic                  btn3no,
	input  logic                  btn3nc,
	output logic [BTN_LED_W-1:0]  btn_led
);

	spi_req_t          req;
	logic              req_valid;
	logic [DATA_W-1:0] rd_data;
	board_pins_t       board_raw;
	board_pins_t       board_s;
	motor_cmd_t        cmd [NUM_MOTORS];
	motor_stat_t       stat [NUM_MOTORS];

	assign board_raw = '{dipsw: dipsw, btn3nc: btn3nc, btn3no: btn3no,
		btn2nc: btn2nc, btn2no: btn2no};

	spi_slave i_spi_slave (
		.clk_100m(clk_100m),
		.Master_rstn(Master_rstn),
		.mclk_0(mclk_0),
		.mosi_0(mosi_0),
		.cs_00(cs_00),
		.miso_0(miso_0),
		.req(req),
		.req_valid(req_valid),
		.rd_data(rd_data)
	);

	input_sync #(
		.payload_t(board_pins_t)
	) i_board_sync (
		.clk_100m(clk_100m),
		.Master_rstn(Master_rstn),
		.d(board_raw),
		.q(board_s)
	);

	reg_bank i_reg_bank (
		.clk_100m(clk_100m),
		.Master_rstn(Master_rstn),
		.req(req),
		.req_valid(req_valid),
		.rd_data(rd_data),
		.board(board_s),
		.btn_led(btn_led),
		.cmd(cmd),
		.stat(stat)
	);

	////////////////////////////////////////////////////////////////////
	// Motor channels
	////////////////////////////////////////////////////////////////////
	for (genvar m = 0; m < NUM_MOTORS; m++)
	begin : g_motor
		motor_pins_t mpins;

		assign mpins = '{quad: '{b: qcb[m], a: qca[m]}, nfault: nfault[m], fgout: fgout[m]};

		motor_channel i_motor (
			.clk_100m(clk_100m),
			.Master_rstn(Master_rstn),
			.pins(mpins),
			.cmd(cmd[m]),
			.stat(stat[m]),
			.pwm(pwm[m]),
			.brake(brake[m]),
			.droff(droff[m])
		);
	end

endmodule

// ==== top_4mb_properties.sv ====
// Driver safety assertions on the top_4mb motor pins, attached to top_4mb with bind
module top_4mb_properties import mb4_pkg::*;
(
	input logic                  clk_100m,
	input logic                  Master_rstn,
	input spi_req_t              req,
	input logic                  req_valid,
	input logic [NUM_MOTORS-1:0] nfault,
	input logic [NUM_MOTORS-1:0] pwm,
	input logic [NUM_MOTORS-1:0] droff
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [NUM_MOTORS-1:0] drv_en;	// Enable bits as last written by the host
	int                    fail_count = 0;

	always_ff @(posedge clk_100m or negedge Master_rstn)
	begin
		if (!Master_rstn)
			drv_en <= '0;
		else if (req_valid && req.wr)
		begin
			for (int m = 0; m < NUM_MOTORS; m++)
			begin
				if (req.addr == ADDR_MOTOR_BASE + ADDR_W'(m) * MOTOR_STRIDE + OFS_DRV_CTRL)
					drv_en[m] <= req.data[DRV_EN_BIT];
			end
		end
	end

	for (genvar m = 0; m < NUM_MOTORS; m++)
	begin : g_motor
		// Driver stays off unless enabled
		a_droff_when_disabled: assert property (@(posedge clk_100m) disable iff (!Master_rstn)
			!drv_en[m] |-> droff[m])
		else
		begin
			$error("droff low while the driver enable is clear");
			fail_count++;
		end

		// Pin synchronizer is two flops deep
		a_pwm_low_on_fault: assert property (@(posedge clk_100m) disable iff (!Master_rstn)
			!$past(nfault[m], 2) |-> !pwm[m])
		else
		begin
			$error("pwm high while synchronized nfault is low");
			fail_count++;
		end

		a_pwm_low_in_reset: assert property (@(posedge clk_100m) !Master_rstn |-> !pwm[m])
		else
		begin
			$error("pwm high during reset");
			fail_count++;
		end
	end

endmodule

bind top_4mb top_4mb_properties i_props (
	.clk_100m(clk_100m),
	.Master_rstn(Master_rstn),
	.req(req),
	.req_valid(req_valid),
	.nfault(nfault),
	.pwm(pwm),
	.droff(droff)
);

// ==== tb_checker.sv ====
// Checker for the motor board testbench, models register writes and pin stimulus and compares
module tb_checker import mb4_pkg::*;
(
	input  logic                  clk_100m,
	input  spi_req_t              xfer,
	input  logic                  xfer_done,
	input  logic [NUM_MOTORS-1:0] qca,
	input  logic [NUM_MOTORS-1:0] qcb,
	input  logic [NUM_MOTORS-1:0] nfault,
	input  logic [NUM_MOTORS-1:0] fgout,
	input  logic [NUM_MOTORS-1:0] pwm,
	input  logic [NUM_MOTORS-1:0] brake,
	input  logic [NUM_MOTORS-1:0] droff,
	input  logic [DIPSW_W-1:0]    dipsw,
	input  logic                  btn2no,
	input  logic                  btn2nc,
	input  logic                  btn3no,
	input  logic                  btn3nc,
	input  logic [BTN_LED_W-1:0]  btn_led,
	input  logic                  win_start,
	input  int                    win_motor,
	output logic                  win_done,
	input  logic                  pin_chk,
	input  logic                  test_done,
	input  int                    test_id,
	input  logic                  all_done,
	output int                    err_count
);

	timeunit 1ns;
	timeprecision 100ps;

	typedef enum int {WIN_IDLE, WIN_SETTLE, WIN_COUNT} win_state_t;

	// Register model
	logic [DATA_W-1:0]    m_count [NUM_MOTORS] = '{default: '0};
	logic [DATA_W-1:0]    m_errs [NUM_MOTORS]  = '{default: '0};
	logic [DATA_W-1:0]    m_pwm [NUM_MOTORS]   = '{default: '0};
	logic                 m_en [NUM_MOTORS]    = '{default: 1'b0};
	logic                 m_brake [NUM_MOTORS] = '{default: 1'b0};
	logic [1:0]           prev_pos [NUM_MOTORS] = '{default: 2'd0};
	logic [BTN_LED_W-1:0] m_led = '0;

	int         errs = 0;
	int         total_checks = 0;
	int         test_errs = 0;
	int         test_checks = 0;
	int         tests = 0;
	win_state_t win_state = WIN_IDLE;
	int         win_m = 0;
	int         win_len = 0;
	int         win_cnt = 0;
	int         highs = 0;

	assign err_count = errs;

	function automatic logic [1:0] phase_pos(input logic a, input logic b);
		case ({b, a})
			2'b00: return 2'd0;
			2'b01: return 2'd1;
			2'b11: return 2'd2;
			default: return 2'd3;
		endcase
	endfunction

	function automatic string test_name(input int id);
		case (id)
			1: return "board registers";
			2: return "buttons";
			3: return "encoder counting";
			4: return "pwm output";
			default: return "driver and fault";
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////
	function automatic logic [DATA_W-1:0] ref_read(input logic [ADDR_W-1:0] addr);
		int rel;
		int m;
		rel = int'(addr) - int'(ADDR_MOTOR_BASE);
		m   = rel / int'(MOTOR_STRIDE);
		if (rel >= 0 && m < NUM_MOTORS)
		begin
			case (rel % int'(MOTOR_STRIDE))
				0: return m_count[m];
				1: return m_errs[m];
				2: return m_pwm[m];
				3: return {30'b0, fgout[m], nfault[m]};
				4: return {30'b0, m_brake[m], m_en[m]};
				default: return UNMAPPED_DATA;
			endcase
		end
		case (addr)
			ADDR_VER: return FPGA_VERSION;
			ADDR_DIP: return DATA_W'(dipsw);
			ADDR_BUTTONS: return {28'b0, btn3nc, btn3no, btn2nc, btn2no};
			ADDR_BUTTON_LED: return DATA_W'(m_led);
			default: return UNMAPPED_DATA;
		endcase
	endfunction

	// High clocks expected in one period window
	function automatic int ref_pwm_highs(input int m);
		int period;
		int high;
		period = int'(m_pwm[m][15:0]);
		high   = int'(m_pwm[m][31:16]);
		if (!m_en[m] || !nfault[m] || period == 0)
			return 0;
		return (high < period) ? high : period;
	endfunction

	task automatic apply_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		int rel;
		int m;
		rel = int'(addr) - int'(ADDR_MOTOR_BASE);
		m   = rel / int'(MOTOR_STRIDE);
		if (addr == ADDR_BUTTON_LED)
			m_led = data[BTN_LED_W-1:0];
		else if (rel >= 0 && m < NUM_MOTORS)
		begin
			case (rel % int'(MOTOR_STRIDE))
				0:
				begin
					m_count[m] = '0;	// Clears both counts
					m_errs[m]  = '0;
				end
				2: m_pwm[m] = data;
				4:
				begin
					m_en[m]    = data[0];
					m_brake[m] = data[1];
				end
				default: ;
			endcase
		end
	endtask

	task automatic check(input string name, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] got);
		test_checks++;
		total_checks++;
		if (got !== exp)
		begin
			test_errs++;
			errs++;
			$display("mismatch at %0d ns: %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	////////////////////////////////////////////////////////////////////
	// Compare process
	////////////////////////////////////////////////////////////////////
	always @(posedge clk_100m)
	begin
		logic [1:0] cur;
		logic [1:0] delta;
		win_done <= 1'b0;
		for (int m = 0; m < NUM_MOTORS; m++)
		begin
			cur   = phase_pos(qca[m], qcb[m]);
			delta = cur - prev_pos[m];
			if (delta == 2'd1)
				m_count[m] = m_count[m] + 1;
			else if (delta == 2'd3)
				m_count[m] = m_count[m] - 1;
			else if (delta == 2'd2)
				m_errs[m] = m_errs[m] + 1;	// Both phases at once
			prev_pos[m] = cur;
		end
		if (xfer_done && xfer.wr)
			apply_write(xfer.addr, xfer.data);
		else if (xfer_done)
			check($sformatf("miso_0 read of %04h", xfer.addr), ref_read(xfer.addr), xfer.data);
		if (pin_chk)
		begin
			check("btn_led", DATA_W'(m_led), DATA_W'(btn_led));
			for (int m = 0; m < NUM_MOTORS; m++)
			begin
				check($sformatf("brake[%0d]", m), DATA_W'(m_brake[m]), DATA_W'(brake[m]));
				check($sformatf("droff[%0d]", m), DATA_W'(!m_en[m] || !nfault[m]),
					DATA_W'(droff[m]));
				if (!m_en[m] || !nfault[m])
					check($sformatf("pwm[%0d]", m), '0, DATA_W'(pwm[m]));
			end
		end
		// One period to settle, then one period counted
		case (win_state)
			WIN_IDLE:
				if (win_start)
				begin
					win_m     = win_motor;
					win_len   = (m_pwm[win_m][15:0] == 0) ? 64 : int'(m_pwm[win_m][15:0]);
					win_cnt   = 0;
					win_state = WIN_SETTLE;
				end
			WIN_SETTLE:
			begin
				win_cnt++;
				if (win_cnt == win_len)
				begin
					win_cnt   = 0;
					highs     = 0;
					win_state = WIN_COUNT;
				end
			end
			default:
			begin
				if (pwm[win_m])
					highs++;
				win_cnt++;
				if (win_cnt == win_len)
				begin
					check($sformatf("pwm[%0d] high clocks", win_m), ref_pwm_highs(win_m), highs);
					win_done  <= 1'b1;
					win_state = WIN_IDLE;
				end
			end
		endcase
		if (test_done)
		begin
			tests++;
			$display("test %0d %s: %s, %0d checks, %0d errors", test_id, test_name(test_id),
				(test_errs == 0) ? "ok" : "FAILED", test_checks, test_errs);
			test_checks = 0;
			test_errs   = 0;
		end
		if (all_done)
			$display("tests %0d, checks %0d, errors %0d", tests, total_checks, errs);
	end

endmodule

// ==== tb_top_4mb.sv ====
// Testbench top for the motor board core: clock, reset, SPI host, pin stimulus and watchdog
module tb_top_4mb import mb4_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int SCLK_HALF   = 4;	// mclk_0 at one eighth of clk_100m
	localparam int FRAME_CYC   = 2 * SCLK_HALF * FRAME_BITS + SCLK_HALF + 10;
	localparam int NUM_FRAMES  = 90;
	localparam int PWM_CYC     = NUM_MOTORS * 3 * (2 * 64 + 4);
	localparam int ENC_CYC     = NUM_MOTORS * 80 * 4;
	localparam int TIMEOUT_CYC = 2 * (NUM_FRAMES * FRAME_CYC + PWM_CYC + ENC_CYC) + 100;

	// Encoder position deltas on the Gray sequence
	localparam logic [1:0] STEP_FWD = 2'd1;
	localparam logic [1:0] STEP_REV = 2'd3;
	localparam logic [1:0] STEP_BAD = 2'd2;

	logic                  clk_100m;
	logic                  Master_rstn;
	logic                  mclk_0;
	logic                  mosi_0;
	logic                  cs_00;
	logic                  miso_0;
	logic [NUM_MOTORS-1:0] qca;
	logic [NUM_MOTORS-1:0] qcb;
	logic [NUM_MOTORS-1:0] nfault;
	logic [NUM_MOTORS-1:0] fgout;
	logic [NUM_MOTORS-1:0] pwm;
	logic [NUM_MOTORS-1:0] brake;
	logic [NUM_MOTORS-1:0] droff;
	logic [DIPSW_W-1:0]    dipsw;
	logic                  btn2no;
	logic                  btn2nc;
	logic                  btn3no;
	logic                  btn3nc;
	logic [BTN_LED_W-1:0]  btn_led;

	spi_req_t   xfer;	// Finished frame, read data in place of write data
	logic       xfer_done;
	logic       win_start;
	int         win_motor;
	logic       win_done;
	logic       pin_chk;
	logic       test_done;
	int         test_id;
	logic       all_done;
	int         err_count;
	logic [1:0] enc_pos [NUM_MOTORS];

	top_4mb i_top_4mb (.*);

	tb_checker i_checker (.*);

	initial
	begin
		clk_100m = 1'b0;
		forever #5 clk_100m = ~clk_100m;
	end

	// Watchdog
	initial
	begin
		repeat (TIMEOUT_CYC) @(posedge clk_100m);
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
		$display("Regression failed");
		$finish;
	end

	task automatic tick(input int n);
		repeat (n) @(posedge clk_100m);
		#1;
	endtask

	function automatic logic [ADDR_W-1:0] motor_addr(input int m, input logic [ADDR_W-1:0] ofs);
		return ADDR_MOTOR_BASE + ADDR_W'(m) * MOTOR_STRIDE + ofs;
	endfunction

	function automatic logic [1:0] gray_of(input logic [1:0] pos);
		case (pos)
			2'd0: return 2'b00;
			2'd1: return 2'b01;
			2'd2: return 2'b11;
			default: return 2'b10;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////
	// SPI host
	////////////////////////////////////////////////////////////////////
	task automatic spi_frame(input logic wr, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data, output logic [DATA_W-1:0] rdata);
		logic [FRAME_BITS-1:0] frame;
		frame = {wr, addr, data};
		rdata = '0;
		cs_00 = 1'b0;
		tick(4);
		for (int i = FRAME_BITS - 1; i >= 0; i--)
		begin
			mosi_0 = frame[i];	// Mode 0, set up while mclk_0 is low
			tick(SCLK_HALF);
			if (i < DATA_W)
				rdata[i] = miso_0;
			mclk_0 = 1'b1;
			tick(SCLK_HALF);
			mclk_0 = 1'b0;
		end
		tick(SCLK_HALF);
		cs_00 = 1'b1;
		tick(4);
	endtask

	task automatic report_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data);
		xfer      = '{wr: wr, addr: addr, data: data};
		xfer_done = 1'b1;
		tick(1);
		xfer_done = 1'b0;
	endtask

	task automatic reg_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		logic [DATA_W-1:0] unused;
		spi_frame(1'b1, addr, data, unused);
		report_xfer(1'b1, addr, data);
	endtask

	task automatic reg_read(input logic [ADDR_W-1:0] addr);
		logic [DATA_W-1:0] rdata;
		spi_frame(1'b0, addr, '0, rdata);
		report_xfer(1'b0, addr, rdata);
	endtask

	////////////////////////////////////////////////////////////////////
	// Pin stimulus and checker requests
	////////////////////////////////////////////////////////////////////
	task automatic enc_step(input int m, input logic [1:0] delta, input int n);
		repeat (n)
		begin
			enc_pos[m] = enc_pos[m] + delta;
			{qcb[m], qca[m]} = gray_of(enc_pos[m]);
			tick(4);	// Longer than the pin synchronizer
		end
	endtask

	task automatic measure_pwm(input int m);
		win_motor = m;
		win_start = 1'b1;
		tick(1);
		win_start = 1'b0;
		while (!win_done)
			tick(1);
	endtask

	task automatic check_pins();
		pin_chk = 1'b1;
		tick(1);
		pin_chk = 1'b0;
	endtask

	task automatic end_test(input int id);
		test_id   = id;
		test_done = 1'b1;
		tick(1);
		test_done = 1'b0;
	endtask

	task automatic run_board_test();
		logic [ADDR_W-1:0] holes [4];
		holes = '{15'h0001, 15'h0006, 15'h0105, 15'h0140};
		reg_read(ADDR_VER);
		repeat (3)
		begin
			dipsw = DIPSW_W'($urandom);
			reg_read(ADDR_DIP);
		end
		foreach (holes[i])
			reg_read(holes[i]);
		end_test(1);
	endtask

	task automatic run_button_test();
		repeat (3)
		begin
			{btn3nc, btn3no, btn2nc, btn2no} = 4'($urandom);
			reg_read(ADDR_BUTTONS);
		end
		repeat (2)
		begin
			reg_write(ADDR_BUTTON_LED, $urandom);
			check_pins();
			reg_read(ADDR_BUTTON_LED);
		end
		end_test(2);
	endtask

	task automatic run_encoder_test();
		for (int m = 0; m < NUM_MOTORS; m++)
		begin
			enc_step(m, STEP_FWD, 5 + $urandom % 30);
			enc_step(m, STEP_REV, $urandom % 30);
			enc_step(m, STEP_BAD, 1 + $urandom % 4);
			enc_step(m, STEP_REV, $urandom % 10);
			reg_read(motor_addr(m, OFS_INC));
			reg_read(motor_addr(m, OFS_INC_ERR));
			reg_write(motor_addr(m, OFS_INC), $urandom);	// Any write clears
			reg_read(motor_addr(m, OFS_INC));
			reg_read(motor_addr(m, OFS_INC_ERR));
		end
		end_test(3);
	endtask

	task automatic run_pwm_test();
		logic [PWM_FIELD_W-1:0] period;
		logic [PWM_FIELD_W-1:0] high;
		for (int m = 0; m < NUM_MOTORS; m++)
		begin
			period = PWM_FIELD_W'(8 + $urandom % 41);
			high   = PWM_FIELD_W'($urandom % (period + 9));	// Sometimes above the period
			reg_write(motor_addr(m, OFS_PWM), {high, period});
			reg_write(motor_addr(m, OFS_DRV_CTRL), 32'h1);
			reg_read(motor_addr(m, OFS_PWM));
			measure_pwm(m);
			reg_write(motor_addr(m, OFS_DRV_CTRL), 32'h0);
			measure_pwm(m);
			reg_write(motor_addr(m, OFS_PWM), {high, 16'h0});
			reg_write(motor_addr(m, OFS_DRV_CTRL), 32'h1);
			measure_pwm(m);
			reg_write(motor_addr(m, OFS_DRV_CTRL), 32'h0);
		end
		end_test(4);
	endtask

	task automatic run_fault_test();
		for (int m = 0; m < NUM_MOTORS; m++)
		begin
			fgout[m] = 1'($urandom);
			reg_write(motor_addr(m, OFS_PWM), {16'd20, 16'd10});	// Output always high
			reg_write(motor_addr(m, OFS_DRV_CTRL), 32'h3);
			check_pins();
			nfault[m] = 1'b0;
			tick(4);
			check_pins();
			reg_read(motor_addr(m, OFS_FEEDBACK));
			nfault[m] = 1'b1;
			tick(4);
			reg_write(motor_addr(m, OFS_DRV_CTRL), 32'h2);	// Brake only
			check_pins();
			reg_read(motor_addr(m, OFS_DRV_CTRL));
			reg_write(motor_addr(m, OFS_DRV_CTRL), 32'h0);
		end
		end_test(5);
	endtask

	initial
	begin
		void'($urandom(32'hc64d));
		Master_rstn = 1'b0;
		mclk_0      = 1'b0;
		mosi_0      = 1'b0;
		cs_00       = 1'b1;
		qca         = '0;
		qcb         = '0;
		nfault      = '1;	// No fault
		fgout       = '0;
		dipsw       = '0;
		btn2no      = 1'b0;
		btn2nc      = 1'b0;
		btn3no      = 1'b0;
		btn3nc      = 1'b0;
		xfer        = '0;
		xfer_done   = 1'b0;
		win_start   = 1'b0;
		win_motor   = 0;
		pin_chk     = 1'b0;
		test_done   = 1'b0;
		test_id     = 0;
		all_done    = 1'b0;
		enc_pos     = '{default: 2'd0};
		repeat (2) @(posedge clk_100m);
		#1;
		Master_rstn = 1'b1;
		tick(4);
		run_board_test();
		run_button_test();
		run_encoder_test();
		run_pwm_test();
		run_fault_test();
		all_done = 1'b1;
		tick(1);
		all_done = 1'b0;
		tick(1);
		if (err_count == 0 && i_top_4mb.i_props.fail_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== build.f ====
mb4_pkg.sv
input_sync.sv
spi_slave.sv
quad_decoder.sv
pwm_gen.sv
motor_channel.sv
reg_bank.sv
top_4mb.sv
top_4mb_properties.sv
tb_checker.sv
tb_top_4mb.sv
